/* Makefile */
# Verilator build and run of the camera pixel pipeline testbench

VERILATOR ?= verilator
TOP ?= camPipe_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG ?= ** FAIL **

SRCS := $(wildcard source/*.sv source/*.svh dv/*.sv)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation reported failure"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/camPipe_chk.sv */
module camPipe_chk
	import camPipe_pkg::*;
(
	input logic iCLK,
	input logic iRST_n,
	input rawBeat_t iRaw,
	input logic iValid,
	input axilReq_t iAxil,
	input axilRsp_t oAxil,
	input logic winValid,
	input logic oValid
);

	// Responses wait for the master's ready
	bHold: assert property (@(posedge iCLK) disable iff (!iRST_n)
		oAxil.bvalid && !iAxil.bready |=> oAxil.bvalid)
		else $error("bvalid dropped before bready");
	rHold: assert property (@(posedge iCLK) disable iff (!iRST_n)
		oAxil.rvalid && !iAxil.rready |=> oAxil.rvalid)
		else $error("rvalid dropped before rready");

	// ----------------------------------------------------------
	// Beat positions and latency
	// ----------------------------------------------------------
	// Start of frame sits at the origin, so it never opens a window
	winFromIn: assert property (@(posedge iCLK) disable iff (!iRST_n)
		winValid |-> $past(iValid) && !$past(iRaw.sof))
		else $error("window beat without a matching input beat");
	// Output three cycles after an accepted beat off the origin
	outLatency: assert property (@(posedge iCLK) disable iff (!iRST_n)
		oValid |-> $past(iValid, 3) && !$past(iRaw.sof, 3))
		else $error("output beat not three cycles after an input beat");
	// Quiet while reset is held
	resetQuiet: assert property (@(posedge iCLK)
		!iRST_n |-> !oValid && !oAxil.bvalid && !oAxil.rvalid)
		else $error("output active during reset");

endmodule

bind camPipe camPipe_chk camPipe_chk_i (
	.iCLK(iCLK),
	.iRST_n(iRST_n),
	.iRaw(iRaw),
	.iValid(iValid),
	.iAxil(iAxil),
	.oAxil(oAxil),
	.winValid(winValid),
	.oValid(oValid)
);

/* dv/camPipe_tb.sv */
`include "camPipe_macros.svh"

module camPipe_tb
	import camPipe_pkg::*;
();

	// Pixels of all frames below, used for the run limit
	localparam int totalPix = 128 + 198 + 24 + 320 + 3 * 96;
	localparam int cycleLimit = 4 * totalPix + 2000;

	logic iCLK;
	logic iRST_n;
	rawBeat_t iRaw;
	logic iValid;
	axilReq_t iAxil;
	axilRsp_t oAxil;
	outBeat_t oPix;
	logic oValid;

	// Reference frame, row then column
	pixel_t img [8][64];
	outBeat_t expQ [$];
	outBeat_t expBeat;
	int errCount;
	int beatCount;
	int outCount;
	int maskCount;
	int cycleCount;
	int testErr;
	int outBefore;
	// Beats the model expects since reset
	int expTotal;
	int thrList [3] = '{0, 2000, 4095};
	logic [31:0] rdData;
	logic [1:0] resp;

	camPipe camPipe_i (
		.iCLK(iCLK),
		.iRST_n(iRST_n),
		.iRaw(iRaw),
		.iValid(iValid),
		.iAxil(iAxil),
		.oAxil(oAxil),
		.oPix(oPix),
		.oValid(oValid)
	);

	initial iCLK = 1'b0;
	always #4 iCLK = ~iCLK;

	// ----------------------------------------------------------
	// Error reporting
	// ----------------------------------------------------------
	task automatic reportMismatch(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERROR t=%0t %s: got %0h expected %0h", $time, sig, got, exp);
		errCount++;
	endtask

	task automatic failNote(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		errCount++;
	endtask

	task automatic reportTest(input int num, input string name, input int errBefore);
		$display("Test %0d %s: %0d errors", num, name, errCount - errBefore);
	endtask

	// ----------------------------------------------------------
	// AXI4-Lite master
	// ----------------------------------------------------------
	// Address and data together, bready held until the response
	task automatic writeReg(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] bresp);
		int waitCnt;
		@(negedge iCLK);
		iAxil.awaddr = addr;
		iAxil.wdata = data;
		iAxil.wstrb = 4'hF;
		iAxil.awvalid = 1'b1;
		iAxil.wvalid = 1'b1;
		iAxil.bready = 1'b1;
		@(negedge iCLK);
		waitCnt = 1;
		while (!oAxil.bvalid && waitCnt < 50)
		begin
			@(negedge iCLK);
			waitCnt++;
		end
		if (!oAxil.bvalid)
			failNote("write got no response on the B channel");
		bresp = oAxil.bresp;
		iAxil.awvalid = 1'b0;
		iAxil.wvalid = 1'b0;
		@(negedge iCLK);
		iAxil.bready = 1'b0;
	endtask

	task automatic readReg(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] rresp);
		int waitCnt;
		@(negedge iCLK);
		iAxil.araddr = addr;
		iAxil.arvalid = 1'b1;
		iAxil.rready = 1'b1;
		@(negedge iCLK);
		waitCnt = 1;
		while (!oAxil.rvalid && waitCnt < 50)
		begin
			@(negedge iCLK);
			waitCnt++;
		end
		if (!oAxil.rvalid)
			failNote("read got no response on the R channel");
		data = oAxil.rdata;
		rresp = oAxil.rresp;
		iAxil.arvalid = 1'b0;
		@(negedge iCLK);
		iAxil.rready = 1'b0;
	endtask

	// ----------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------
	// RGGB: 0 red, 1 green, 2 blue
	function automatic int colourAt(input int x, input int y);
		if (y % 2 == 0)
			colourAt = (x % 2 == 0) ? 0 : 1;
		else
			colourAt = (x % 2 == 0) ? 1 : 2;
	endfunction

	// Window of the pixel, its left, above and above-left
	task automatic expectBeat(input int x, input int y, input pixel_t thr);
		outBeat_t beat;
		int greenSum;
		int luma;
		beat = '0;
		greenSum = 0;
		for (int dy = 0; dy < 2; dy++)
		begin
			for (int dx = 0; dx < 2; dx++)
			begin
				case (colourAt(x - dx, y - dy))
					0: beat.rgb.red = img[y - dy][x - dx];
					1: greenSum += int'(img[y - dy][x - dx]);
					default: beat.rgb.blue = img[y - dy][x - dx];
				endcase
			end
		end
		beat.rgb.green = pixel_t'(greenSum / 2);
		luma = (int'(beat.rgb.red) + 2 * int'(beat.rgb.green) + int'(beat.rgb.blue)) / 4;
		beat.mask = (luma > int'(thr));
		expQ.push_back(beat);
		expTotal++;
	endtask

	// Random frame, model first, then driven and drained
	task automatic runFrame(input int width, input int height, input bit gaps,
		input pixel_t thr);
		for (int y = 0; y < height; y++)
		begin
			for (int x = 0; x < width; x++)
			begin
				// Black top-left corner gives windows with zero luma
				img[y][x] = ((x < 3 && y < 3) || $urandom % 8 == 0) ? '0 : pixel_t'($urandom);
				if (x >= 1 && y >= 1)
					expectBeat(x, y, thr);
			end
		end
		for (int y = 0; y < height; y++)
		begin
			for (int x = 0; x < width; x++)
			begin
				@(negedge iCLK);
				if (gaps && $urandom % 4 == 0)
				begin
					iValid = 1'b0;
					@(negedge iCLK);
				end
				iRaw.sof = (x == 0 && y == 0);
				iRaw.pix = img[y][x];
				iValid = 1'b1;
			end
		end
		@(negedge iCLK);
		iValid = 1'b0;
		iRaw.sof = 1'b0;
		while (expQ.size() != 0)
			@(negedge iCLK);
	endtask

	// Outputs change on posedge, sampled at negedge
	always @(negedge iCLK)
	begin
		if (iRST_n && oValid)
		begin
			outCount++;
			if (oPix.mask)
				maskCount++;
			if (expQ.size() == 0)
				failNote("output beat appeared with none expected");
			else
			begin
				expBeat = expQ.pop_front();
				beatCount++;
				if (oPix.rgb.red !== expBeat.rgb.red)
					reportMismatch("oPix.rgb.red", oPix.rgb.red, expBeat.rgb.red);
				if (oPix.rgb.green !== expBeat.rgb.green)
					reportMismatch("oPix.rgb.green", oPix.rgb.green, expBeat.rgb.green);
				if (oPix.rgb.blue !== expBeat.rgb.blue)
					reportMismatch("oPix.rgb.blue", oPix.rgb.blue, expBeat.rgb.blue);
				if (oPix.mask !== expBeat.mask)
					reportMismatch("oPix.mask", oPix.mask, expBeat.mask);
			end
		end
	end

	// Run limit from the frame sizes
	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge iCLK);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, outputs or bus responses missing", cycleCount);
		$display("** FAIL **");
		$finish;
	end

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------
	initial
	begin
		void'($urandom(84));
		iRST_n = 1'b0;
		iValid = 1'b0;
		iRaw = '0;
		iAxil = '0;
		errCount = 0;
		beatCount = 0;
		outCount = 0;
		maskCount = 0;
		expTotal = 0;
		repeat (2) @(posedge iCLK);
		@(negedge iCLK);
		iRST_n = 1'b1;

		testErr = errCount;
		readReg(`REG_WIDTH, rdData, resp);
		if (rdData !== 32'd16) reportMismatch("lineWidth", rdData, 32'd16);
		if (resp !== 2'b00) reportMismatch("rresp", resp, 2'b00);
		readReg(`REG_THRESH, rdData, resp);
		if (rdData !== 32'd128) reportMismatch("threshold", rdData, 32'd128);
		readReg(`REG_COUNT, rdData, resp);
		if (rdData !== 32'd0) reportMismatch("pixCount", rdData, 32'd0);
		writeReg(`REG_WIDTH, 32'd40, resp);
		if (resp !== 2'b00) reportMismatch("bresp", resp, 2'b00);
		writeReg(`REG_THRESH, 32'd3000, resp);
		readReg(`REG_WIDTH, rdData, resp);
		if (rdData !== 32'd40) reportMismatch("lineWidth", rdData, 32'd40);
		readReg(`REG_THRESH, rdData, resp);
		if (rdData !== 32'd3000) reportMismatch("threshold", rdData, 32'd3000);
		reportTest(1, "register reset values and read back", testErr);

		testErr = errCount;
		outBefore = outCount;
		writeReg(`REG_WIDTH, 32'd16, resp);
		writeReg(`REG_THRESH, 32'd128, resp);
		runFrame(16, 8, 1'b0, 12'd128);
		if (outCount - outBefore != 15 * 7) reportMismatch("beats", outCount - outBefore, 105);
		reportTest(2, "single 16x8 frame", testErr);

		// Width write lands mid-frame, the next frame uses it
		testErr = errCount;
		writeReg(`REG_WIDTH, 32'd33, resp);
		fork
			runFrame(33, 6, 1'b1, 12'd128);
			begin
				repeat (40) @(negedge iCLK);
				writeReg(`REG_WIDTH, 32'd4, resp);
			end
		join
		runFrame(4, 6, 1'b1, 12'd128);
		writeReg(`REG_WIDTH, 32'd64, resp);
		runFrame(64, 5, 1'b1, 12'd128);
		reportTest(3, "widths 33, 4 and 64 with gaps", testErr);

		testErr = errCount;
		writeReg(`REG_WIDTH, 32'd16, resp);
		foreach (thrList[i])
		begin
			writeReg(`REG_THRESH, 32'(thrList[i]), resp);
			maskCount = 0;
			runFrame(16, 6, 1'b1, pixel_t'(thrList[i]));
			if (thrList[i] == 4095 && maskCount != 0)
				failNote("mask set while the threshold is 4095");
		end
		reportTest(4, "thresholds 0, 2000 and 4095", testErr);

		testErr = errCount;
		readReg(`REG_COUNT, rdData, resp);
		if (rdData !== 32'(expTotal)) reportMismatch("pixCount", rdData, 32'(expTotal));
		writeReg(`REG_COUNT, 32'd5, resp);
		readReg(`REG_COUNT, rdData, resp);
		if (rdData !== 32'd0) reportMismatch("pixCount", rdData, 32'd0);
		reportTest(5, "output counter and clear", testErr);

		testErr = errCount;
		readReg(4'hC, rdData, resp);
		if (resp !== 2'b10) reportMismatch("rresp", resp, 2'b10);
		if (rdData !== 32'd0) reportMismatch("rdata", rdData, 32'd0);
		writeReg(4'hC, 32'hFFFF, resp);
		if (resp !== 2'b10) reportMismatch("bresp", resp, 2'b10);
		reportTest(6, "unknown address answers SLVERR", testErr);

		$display("Summary: 6 tests, %0d beats checked, %0d errors", beatCount, errCount);
		if (errCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* source/bayerDemosaic.sv */
`include "camPipe_macros.svh"

module bayerDemosaic
	import camPipe_pkg::*;
(
	input logic iCLK,
	input logic iRST_n,
	input winBeat_t win,
	input logic winValid,
	output rgbBeat_t rgb,
	output logic rgbValid
);

	pixel_t redSel;
	pixel_t blueSel;
	pixel_t greenA;
	pixel_t greenB;
	green_t greenSum;

	// ----------------------------------------------------------
	// Colour selection by phase
	// ----------------------------------------------------------
	// RGGB: red on even/even, blue on odd/odd
	always_comb
	begin
		case ({win.oddY, win.oddX})
			// Current is red, diagonal is blue
			2'b00:
			begin
				redSel = win.cur;
				blueSel = win.upLeft;
				greenA = win.left;
				greenB = win.up;
			end
			// Current is green on a red row
			2'b01:
			begin
				redSel = win.left;
				blueSel = win.up;
				greenA = win.cur;
				greenB = win.upLeft;
			end
			// Current is green on a blue row
			2'b10:
			begin
				redSel = win.up;
				blueSel = win.left;
				greenA = win.cur;
				greenB = win.upLeft;
			end
			// Current is blue, diagonal is red
			default:
			begin
				redSel = win.upLeft;
				blueSel = win.cur;
				greenA = win.left;
				greenB = win.up;
			end
		endcase
	end

	// Average of the two greens, carry kept
	assign greenSum = green_t'(greenA) + green_t'(greenB);

	// ----------------------------------------------------------
	// Output register
	// ----------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (winValid)
		begin
			rgb.red <= redSel;
			rgb.green <= greenSum[`PIX_W:1];
			rgb.blue <= blueSel;
		end
	end

	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
			rgbValid <= 1'b0;
		else
			rgbValid <= winValid;
	end

endmodule

/* source/bayerWindow.sv */
`include "camPipe_macros.svh"

module bayerWindow
	import camPipe_pkg::*;
(
	input logic iCLK,
	input logic iRST_n,
	input coord_t lineWidth,
	input rawBeat_t raw,
	input logic rawValid,
	output winBeat_t win,
	output logic winValid
);

	localparam int memAw = $clog2(`LINE_MAX);

	coord_t col;
	coord_t row;
	coord_t widthQ;
	coord_t curX;
	coord_t curY;
	coord_t curWidth;
	pixel_t lineMem [`LINE_MAX];
	pixel_t upNow;
	pixel_t prevCur;
	pixel_t prevUp;

	// ----------------------------------------------------------
	// Position of the beat on the input
	// ----------------------------------------------------------
	// Start of frame forces the origin
	assign curX = raw.sof ? '0 : col;
	assign curY = raw.sof ? '0 : row;
	// Width taken from the register only at start of frame
	assign curWidth = raw.sof ? lineWidth : widthQ;

	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			col <= '0;
			row <= '0;
			widthQ <= `DEF_WIDTH;
		end
		else if (rawValid)
		begin
			if (raw.sof)
				widthQ <= lineWidth;
			// Last column wraps to the next row
			if (curX == curWidth - 1'b1)
			begin
				col <= '0;
				row <= curY + 1'b1;
			end
			else
			begin
				col <= curX + 1'b1;
				row <= curY;
			end
		end
	end

	// ----------------------------------------------------------
	// Previous line and the 2x2 window
	// ----------------------------------------------------------
	// Old content at this column is the pixel above
	assign upNow = lineMem[curX[memAw-1:0]];

	always_ff @(posedge iCLK)
	begin
		if (rawValid)
		begin
			lineMem[curX[memAw-1:0]] <= raw.pix;
			// One beat back gives the left column
			prevCur <= raw.pix;
			prevUp <= upNow;
			win.cur <= raw.pix;
			win.left <= prevCur;
			win.up <= upNow;
			win.upLeft <= prevUp;
			win.oddX <= curX[0];
			win.oddY <= curY[0];
		end
	end

	// Row 0 and column 0 have no full window
	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
			winValid <= 1'b0;
		else
			winValid <= rawValid && (curX != '0) && (curY != '0);
	end

endmodule

/* source/camPipe.sv */
module camPipe
	import camPipe_pkg::*;
(
	input logic iCLK,
	input logic iRST_n,
	input rawBeat_t iRaw,
	input logic iValid,
	input axilReq_t iAxil,
	output axilRsp_t oAxil,
	output outBeat_t oPix,
	output logic oValid
);

	// Configuration from the register block
	coord_t lineWidth;
	pixel_t threshold;

	// Stage to stage beats
	winBeat_t win;
	logic winValid;
	rgbBeat_t rgb;
	logic rgbValid;

	// ----------------------------------------------------------
	// Register block
	// ----------------------------------------------------------
	// Counter fed by the final valid
	cfgRegs cfgRegs_i (
		.iCLK(iCLK),
		.iRST_n(iRST_n),
		.iAxil(iAxil),
		.oAxil(oAxil),
		.pixDone(oValid),
		.lineWidth(lineWidth),
		.threshold(threshold)
	);

	// ----------------------------------------------------------
	// Pixel pipeline, one register per stage
	// ----------------------------------------------------------
	bayerWindow bayerWindow_i (
		.iCLK(iCLK),
		.iRST_n(iRST_n),
		.lineWidth(lineWidth),
		.raw(iRaw),
		.rawValid(iValid),
		.win(win),
		.winValid(winValid)
	);

	bayerDemosaic bayerDemosaic_i (
		.iCLK(iCLK),
		.iRST_n(iRST_n),
		.win(win),
		.winValid(winValid),
		.rgb(rgb),
		.rgbValid(rgbValid)
	);

	// Luma and mask on the last stage
	lumaThreshold lumaThreshold_i (
		.iCLK(iCLK),
		.iRST_n(iRST_n),
		.threshold(threshold),
		.rgb(rgb),
		.rgbValid(rgbValid),
		.pix(oPix),
		.pixValid(oValid)
	);

endmodule

/* source/camPipe_macros.svh */
`ifndef CAMPIPE_MACROS_SVH
`define CAMPIPE_MACROS_SVH

// ----------------------------------------------------------
// Pixel and line geometry
// ----------------------------------------------------------
// Raw sample width
`define PIX_W 12
// Longest line held in the line memory
`define LINE_MAX 64
// Column or row index, wide enough for LINE_MAX itself
`define COORD_W 7

// Values after reset
`define DEF_WIDTH 7'd16
`define DEF_THRESH 12'd128

// ----------------------------------------------------------
// Register byte addresses on the AXI4-Lite port
// ----------------------------------------------------------
`define REG_WIDTH 4'h0
`define REG_THRESH 4'h4
`define REG_COUNT 4'h8

`endif

/* source/camPipe_pkg.sv */
`include "camPipe_macros.svh"

package camPipe_pkg;

	// Widths with a meaning
	typedef logic [`PIX_W-1:0] pixel_t;
	typedef logic [`COORD_W-1:0] coord_t;
	// Sum of two greens, one bit wider than a sample
	typedef logic [`PIX_W:0] green_t;

	// ----------------------------------------------------------
	// Pixel path beats
	// ----------------------------------------------------------
	typedef struct packed {
		logic sof;
		pixel_t pix;
	} rawBeat_t;

	// 2x2 window plus the phase of the current pixel
	typedef struct packed {
		pixel_t cur;
		pixel_t left;
		pixel_t up;
		pixel_t upLeft;
		logic oddX;
		logic oddY;
	} winBeat_t;

	typedef struct packed {
		pixel_t red;
		pixel_t green;
		pixel_t blue;
	} rgbBeat_t;

	typedef struct packed {
		rgbBeat_t rgb;
		logic mask;
	} outBeat_t;

	// ----------------------------------------------------------
	// AXI4-Lite register port
	// ----------------------------------------------------------
	// Master to slave
	typedef struct packed {
		logic [3:0] awaddr;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
		logic [3:0] araddr;
		logic arvalid;
		logic rready;
	} axilReq_t;

	// Slave to master
	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [31:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axilRsp_t;

	// Write response machine
	typedef enum logic {
		idle,
		resp
	} axilState_t;

endpackage

/* source/cfgRegs.sv */
`include "camPipe_macros.svh"

module cfgRegs
	import camPipe_pkg::*;
(
	input logic iCLK,
	input logic iRST_n,
	input axilReq_t iAxil,
	output axilRsp_t oAxil,
	input logic pixDone,
	output coord_t lineWidth,
	output pixel_t threshold
);

	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	axilState_t wrState;
	logic wrFire;
	logic rdFire;
	logic [1:0] bRespQ;
	logic rValidQ;
	logic [31:0] rDataQ;
	logic [1:0] rRespQ;
	logic [31:0] pixCount;

	// Only the three register offsets answer OKAY
	function automatic logic isKnown(input logic [3:0] addr);
		isKnown = (addr == `REG_WIDTH) || (addr == `REG_THRESH) || (addr == `REG_COUNT);
	endfunction

	// Address and data are taken together, one write at a time
	assign wrFire = (wrState == idle) && iAxil.awvalid && iAxil.wvalid;
	// New read only once the previous data has been taken
	assign rdFire = !rValidQ && iAxil.arvalid;

	always_comb
	begin
		oAxil.awready = wrFire;
		oAxil.wready = wrFire;
		oAxil.bresp = bRespQ;
		oAxil.bvalid = (wrState == resp);
		oAxil.arready = !rValidQ;
		oAxil.rdata = rDataQ;
		oAxil.rresp = rRespQ;
		oAxil.rvalid = rValidQ;
	end

	// ----------------------------------------------------------
	// Write channel
	// ----------------------------------------------------------
	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			wrState <= idle;
			bRespQ <= respOkay;
		end
		else
		begin
			case (wrState)
				idle:
				begin
					if (wrFire)
					begin
						wrState <= resp;
						bRespQ <= isKnown(iAxil.awaddr) ? respOkay : respSlvErr;
					end
				end
				// Hold bvalid until the master takes it
				resp:
				begin
					if (iAxil.bready)
						wrState <= idle;
				end
				default: wrState <= idle;
			endcase
		end
	end

	// Register file and output pixel counter
	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			lineWidth <= `DEF_WIDTH;
			threshold <= `DEF_THRESH;
			pixCount <= '0;
		end
		else
		begin
			if (wrFire && iAxil.awaddr == `REG_WIDTH && iAxil.wstrb[0])
				lineWidth <= iAxil.wdata[`COORD_W-1:0];
			// Threshold spans two byte lanes
			if (wrFire && iAxil.awaddr == `REG_THRESH && iAxil.wstrb[0])
				threshold[7:0] <= iAxil.wdata[7:0];
			if (wrFire && iAxil.awaddr == `REG_THRESH && iAxil.wstrb[1])
				threshold[`PIX_W-1:8] <= iAxil.wdata[`PIX_W-1:8];
			// Clear wins over a pixel in the same cycle
			if (wrFire && iAxil.awaddr == `REG_COUNT)
				pixCount <= '0;
			else if (pixDone)
				pixCount <= pixCount + 32'd1;
		end
	end

	// ----------------------------------------------------------
	// Read channel
	// ----------------------------------------------------------
	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
			rValidQ <= 1'b0;
		else if (rdFire)
			rValidQ <= 1'b1;
		else if (iAxil.rready)
			rValidQ <= 1'b0;
	end

	// Read data captured on acceptance, held while rvalid waits
	always_ff @(posedge iCLK)
	begin
		if (rdFire)
		begin
			rRespQ <= respOkay;
			case (iAxil.araddr)
				`REG_WIDTH: rDataQ <= 32'(lineWidth);
				`REG_THRESH: rDataQ <= 32'(threshold);
				`REG_COUNT: rDataQ <= pixCount;
				default:
				begin
					rDataQ <= '0;
					rRespQ <= respSlvErr;
				end
			endcase
		end
	end

endmodule

/* source/lumaThreshold.sv */
`include "camPipe_macros.svh"

module lumaThreshold
	import camPipe_pkg::*;
(
	input logic iCLK,
	input logic iRST_n,
	input pixel_t threshold,
	input rgbBeat_t rgb,
	input logic rgbValid,
	output outBeat_t pix,
	output logic pixValid
);

	// R + 2G + B never overflows two extra bits
	logic [`PIX_W+1:0] lumaSum;
	pixel_t luma;

	assign lumaSum = {2'b00, rgb.red} + {1'b0, rgb.green, 1'b0} + {2'b00, rgb.blue};
	// Divide by 4
	assign luma = lumaSum[`PIX_W+1:2];

	// ----------------------------------------------------------
	// Output register with mask
	// ----------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (rgbValid)
		begin
			pix.rgb <= rgb;
			// Strictly above threshold
			pix.mask <= (luma > threshold);
		end
	end

	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
			pixValid <= 1'b0;
		else
			pixValid <= rgbValid;
	end

endmodule

/* verilog.f */
+incdir+source
source/camPipe_pkg.sv
source/cfgRegs.sv
source/bayerWindow.sv
source/bayerDemosaic.sv
source/lumaThreshold.sv
source/camPipe.sv
dv/camPipe_chk.sv
dv/camPipe_tb.sv
